// ==== issueSelPkg.sv ====
// Sizes are fixed and shape every port struct; port A is bit 0 of every mask
package issueSelPkg;

	localparam int NUM_ENTRIES = 32; // Issue-queue entries
	localparam int ENTRY_BITS = 5; // Width of an entry index
	localparam int BLOCK_SIZE = 8; // Entries per first-level block
	localparam int NUM_BLOCKS = NUM_ENTRIES / BLOCK_SIZE;
	localparam int NUM_PORTS = 3; // Issue ports A, B, C

	// One bit per queue entry
	typedef logic [NUM_ENTRIES-1:0] reqVecT;

	// Bit 0 enables port A, bit 2 port C
	typedef logic [NUM_PORTS-1:0] portMaskT;

	typedef logic [BLOCK_SIZE-1:0] blockPickT;

	// Input beat
	typedef struct packed {
		reqVecT req; // Ready entries
		portMaskT portEnable; // Enabled issue ports
	} reqBeatT;

	// Stage 1 result with the ranked local picks of every block
	typedef struct packed {
		blockPickT [NUM_BLOCKS-1:0][NUM_PORTS-1:0] pick; // One-hot, indexed [block][rank]
		logic [NUM_BLOCKS-1:0][NUM_PORTS-1:0] has; // Block holds more than rank requests
		portMaskT portEnable; // Carried through to stage 2
	} blockCandT;

	// Stage 2 result holding one full-width one-hot grant per port
	typedef struct packed {
		reqVecT [NUM_PORTS-1:0] vec;
	} grantVecT;

	// Grant of a single port
	typedef struct packed {
		logic valid;
		logic [ENTRY_BITS-1:0] entry; // Encoded form of vector
		reqVecT vector; // One-hot grant
	} portGrantT;

	// Final output with port[0] as port A
	typedef struct packed {
		portGrantT [NUM_PORTS-1:0] port;
	} grantOutT;

endpackage

// ==== cascadePick.sv ====
// Combinational; pick_o vectors are one-hot or zero, a disabled port always gets zero
module cascadePick #(
	parameter int width = 8
) (
	input  logic [width-1:0] cand_i,
	input  issueSelPkg::portMaskT portEnable_i,
	output logic [issueSelPkg::NUM_PORTS-1:0][width-1:0] pick_o,
	output logic [issueSelPkg::NUM_PORTS-1:0] has_o
);

	logic [issueSelPkg::NUM_PORTS-1:0][width-1:0] rank; // Rank k is the (k+1)th lowest set bit
	logic [width-1:0] remain; // Candidates not yet ranked
	int rankIdx; // Next rank to hand out

	// Peel off the lowest set bit once per rank
	always_comb
	begin
		remain = cand_i;
		for (int k = 0; k < issueSelPkg::NUM_PORTS; k++)
		begin
			rank[k] = remain & (~remain + 1'b1); // Isolate lowest set bit
			remain = remain & ~rank[k];
			has_o[k] = |rank[k]; // At least k+1 bits set
		end
	end

	// Enable table
	// Enabled ports, in order A, B, C, take ranks in order; skipped ports consume no rank
	always_comb
	begin
		rankIdx = 0;
		for (int p = 0; p < issueSelPkg::NUM_PORTS; p++)
		begin
			pick_o[p] = '0;
			if (portEnable_i[p])
			begin
				pick_o[p] = rank[rankIdx];
				rankIdx = rankIdx + 1;
			end
		end
	end

endmodule

// ==== blockSelect.sv ====
// Stage 1; ranks requests inside each block with all ports enabled, loads only on advance_i
module blockSelect (
	input  logic clk,
	input  logic rstN_i,
	input  logic advance_i,
	input  logic inValid_i,
	input  issueSelPkg::reqBeatT inBeat_i,
	output logic outValid_o,
	output issueSelPkg::blockCandT cand_o
);

	logic [issueSelPkg::NUM_BLOCKS-1:0][issueSelPkg::NUM_PORTS-1:0]
		[issueSelPkg::BLOCK_SIZE-1:0] blkPick;
	logic [issueSelPkg::NUM_BLOCKS-1:0][issueSelPkg::NUM_PORTS-1:0] blkHas;
	issueSelPkg::blockCandT nextCand;

	// Local pick per block of entries
	for (genvar b = 0; b < issueSelPkg::NUM_BLOCKS; b++)
	begin : gBlock
		cascadePick #(
			.width(issueSelPkg::BLOCK_SIZE)
		) i_localPick (
			.cand_i(inBeat_i.req[b*issueSelPkg::BLOCK_SIZE +: issueSelPkg::BLOCK_SIZE]),
			.portEnable_i('1), // Ranks only since ports are resolved in stage 2
			.pick_o(blkPick[b]),
			.has_o(blkHas[b])
		);
	end

	always_comb
	begin
		for (int b = 0; b < issueSelPkg::NUM_BLOCKS; b++)
		begin
			for (int r = 0; r < issueSelPkg::NUM_PORTS; r++)
			begin
				nextCand.pick[b][r] = blkPick[b][r];
				nextCand.has[b][r] = blkHas[b][r];
			end
		end
		nextCand.portEnable = inBeat_i.portEnable;
	end

	// Stage valid
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			outValid_o <= 1'b0;
		else if (advance_i)
			outValid_o <= inValid_i; // Bubbles move like beats
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (advance_i)
			cand_o <= nextCand;
	end

endmodule

// ==== treeSelect.sv ====
// Stage 2; relies on stage 1 flags being monotonic per block, loads only on advance_i
module treeSelect (
	input  logic clk,
	input  logic rstN_i,
	input  logic advance_i,
	input  logic inValid_i,
	input  issueSelPkg::blockCandT cand_i,
	output logic outValid_o,
	output issueSelPkg::grantVecT grantVec_o
);

	localparam int treeWidth = issueSelPkg::NUM_BLOCKS * issueSelPkg::NUM_PORTS;

	logic [treeWidth-1:0] treeCand; // Bit b*NUM_PORTS+r is block b, rank r
	logic [issueSelPkg::NUM_PORTS-1:0][treeWidth-1:0] treePick;
	issueSelPkg::grantVecT nextVec;

	// Block-major packing of the flags already gives block then rank order,
	// which is also ascending entry order across the whole queue
	assign treeCand = cand_i.has;

	cascadePick #(
		.width(treeWidth)
	) i_globalPick (
		.cand_i(treeCand),
		.portEnable_i(cand_i.portEnable), // Real enables applied here
		.pick_o(treePick),
		.has_o()
	);

	// Place the chosen local pick at its block offset
	always_comb
	begin
		nextVec = '0;
		for (int p = 0; p < issueSelPkg::NUM_PORTS; p++)
		begin
			for (int b = 0; b < issueSelPkg::NUM_BLOCKS; b++)
			begin
				for (int r = 0; r < issueSelPkg::NUM_PORTS; r++)
				begin
					if (treePick[p][b*issueSelPkg::NUM_PORTS + r])
						nextVec.vec[p][b*issueSelPkg::BLOCK_SIZE +: issueSelPkg::BLOCK_SIZE] =
							cand_i.pick[b][r];
				end
			end
		end
	end

	// Stage valid
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			outValid_o <= 1'b0;
		else if (advance_i)
			outValid_o <= inValid_i;
	end

	// Payload
	always_ff @(posedge clk)
	begin
		if (advance_i)
			grantVec_o <= nextVec;
	end

endmodule

// ==== grantEncode.sv ====
// Stage 3; grant vectors must be one-hot or zero, advance_o is the only pipeline enable
module grantEncode (
	input  logic clk,
	input  logic rstN_i,
	input  logic inValid_i,
	input  issueSelPkg::grantVecT grantVec_i,
	input  logic grantReady_i,
	output logic advance_o,
	output logic grantValid_o,
	output issueSelPkg::grantOutT grant_o
);

	issueSelPkg::grantOutT nextGrant;

	// Output register empty or being drained
	assign advance_o = !grantValid_o || grantReady_i;

	// One-hot to index by OR of the positions
	always_comb
	begin
		for (int p = 0; p < issueSelPkg::NUM_PORTS; p++)
		begin
			nextGrant.port[p].vector = grantVec_i.vec[p];
			nextGrant.port[p].valid = |grantVec_i.vec[p]; // Port got an entry
			nextGrant.port[p].entry = '0;
			for (int i = 0; i < issueSelPkg::NUM_ENTRIES; i++)
			begin
				if (grantVec_i.vec[p][i])
					nextGrant.port[p].entry |= i[issueSelPkg::ENTRY_BITS-1:0];
			end
		end
	end

	// Output valid
	always_ff @(posedge clk)
	begin
		if (!rstN_i)
			grantValid_o <= 1'b0;
		else if (advance_o)
			grantValid_o <= inValid_i;
	end

	// Held steady while stalled
	always_ff @(posedge clk)
	begin
		if (advance_o)
			grant_o <= nextGrant;
	end

endmodule

// ==== issueSelect.sv ====
// Three-stage select pipeline, 3 cycles from accepted beat to grant; stages move in lockstep
module issueSelect (
	input  logic clk,
	input  logic rstN_i,
	input  logic reqValid_i,
	input  issueSelPkg::reqBeatT reqBeat_i,
	output logic reqReady_o,
	output logic grantValid_o,
	output issueSelPkg::grantOutT grant_o,
	input  logic grantReady_i
);

	logic advance; // Common load enable of all stages
	logic blkValid;
	issueSelPkg::blockCandT blkCand;
	logic treeValid;
	issueSelPkg::grantVecT grantVec;

	assign reqReady_o = advance;

	blockSelect i_blockSelect (
		.clk(clk),
		.rstN_i(rstN_i),
		.advance_i(advance),
		.inValid_i(reqValid_i),
		.inBeat_i(reqBeat_i),
		.outValid_o(blkValid),
		.cand_o(blkCand)
	);

	treeSelect i_treeSelect (
		.clk(clk),
		.rstN_i(rstN_i),
		.advance_i(advance),
		.inValid_i(blkValid),
		.cand_i(blkCand),
		.outValid_o(treeValid),
		.grantVec_o(grantVec)
	);

	grantEncode i_grantEncode (
		.clk(clk),
		.rstN_i(rstN_i),
		.inValid_i(treeValid),
		.grantVec_i(grantVec),
		.grantReady_i(grantReady_i),
		.advance_o(advance),
		.grantValid_o(grantValid_o),
		.grant_o(grant_o)
	);

endmodule

// ==== tb_issueSelect.sv ====
// Inputs change on the falling edge; grants are checked in order against a scan model
module tb_issueSelect;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD = 8;
	localparam int MAX_STALL = 6; // Longest back-pressure stretch
	localparam int RAND_BEATS = 40;
	localparam int PATTERN_VECS = 6; // Vectors per enable pattern
	localparam int CORNER_VECS = 4;
	localparam int STREAM_BEATS = 32;
	localparam int STALL_BEATS = 40;
	localparam int TOTAL_BEATS = RAND_BEATS + 8 * PATTERN_VECS + 8 * CORNER_VECS
		+ STREAM_BEATS + STALL_BEATS;
	localparam int WATCHDOG_NS = TOTAL_BEATS * (3 + MAX_STALL) * CLK_PERIOD + 2000;

	logic clk;
	logic rstN_i;
	logic reqValid_i;
	issueSelPkg::reqBeatT reqBeat_i;
	logic reqReady_o;
	logic grantValid_o;
	issueSelPkg::grantOutT grant_o;
	logic grantReady_i;

	issueSelPkg::grantOutT expQ[$]; // Expected grants in acceptance order
	int acceptQ[$]; // Cycle of each acceptance
	issueSelPkg::grantOutT heldGrant;
	bit [2:0] modelValid = '0; // Stage valids of the lockstep pipeline, bit 2 is the output
	bit holdPending = 1'b0;
	bit latencyCheck = 1'b0;
	bit stallMode = 1'b0;
	int cycle = 0;
	int beatCount = 0;
	int grantsSeen = 0;
	int stallCycles = 0;
	string testName = "reset";

	issueSelect i_dut (
		.clk(clk),
		.rstN_i(rstN_i),
		.reqValid_i(reqValid_i),
		.reqBeat_i(reqBeat_i),
		.reqReady_o(reqReady_o),
		.grantValid_o(grantValid_o),
		.grant_o(grant_o),
		.grantReady_i(grantReady_i)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic failRun(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkGrant(input issueSelPkg::grantOutT expected,
		input issueSelPkg::grantOutT actual);
		if (actual !== expected)
			failRun($sformatf("error test=%s expected=%h actual=%h", testName, expected, actual));
	endtask

	task automatic checkReady(input bit expected);
		if (reqReady_o !== expected)
			failRun($sformatf("error test=%s reqReady_o expected=%0b actual=%0b",
				testName, expected, reqReady_o));
	endtask

	task automatic checkValid(input bit expected);
		if (grantValid_o !== expected)
			failRun($sformatf("error test=%s grantValid_o expected=%0b actual=%0b",
				testName, expected, grantValid_o));
	endtask

	// Scan from entry 0 handing each set bit to the next enabled port not yet served
	function automatic issueSelPkg::grantOutT expectedGrant(input issueSelPkg::reqBeatT beat);
		issueSelPkg::grantOutT result;
		int port;
		result = '0;
		port = 0;
		for (int i = 0; i < issueSelPkg::NUM_ENTRIES; i++)
		begin
			if (beat.req[i])
			begin
				while (port < issueSelPkg::NUM_PORTS && !beat.portEnable[port])
					port++;
				if (port < issueSelPkg::NUM_PORTS)
				begin
					result.port[port].valid = 1'b1;
					result.port[port].entry = i[issueSelPkg::ENTRY_BITS-1:0];
					result.port[port].vector[i] = 1'b1;
					port++;
				end
			end
		end
		return result;
	endfunction

	// Mix of dense, sparse and single-bit vectors
	function automatic issueSelPkg::reqVecT randomReq(input int n);
		issueSelPkg::reqVecT req;
		req = $urandom;
		if (n % 3 == 1)
			req = req & $urandom & $urandom & $urandom;
		if (n % 5 == 0)
			req = issueSelPkg::reqVecT'(1) << ($urandom % issueSelPkg::NUM_ENTRIES);
		return req;
	endfunction

	// Called at a falling edge and returns at the falling edge after acceptance
	task automatic sendBeat(input issueSelPkg::reqVecT req, input issueSelPkg::portMaskT en);
		reqValid_i = 1'b1;
		reqBeat_i.req = req;
		reqBeat_i.portEnable = en;
		@(posedge clk);
		while (!reqReady_o)
			@(posedge clk);
		@(negedge clk);
		reqValid_i = 1'b0;
		beatCount++;
	endtask

	task automatic waitDrain();
		while (expQ.size() != 0)
			@(negedge clk);
	endtask

	// Scoreboard sampling values settled before the rising edge
	always @(posedge clk)
	begin : monitor
		issueSelPkg::grantOutT expected;
		int latency;
		bit expAdvance;
		cycle = cycle + 1;
		if (rstN_i)
		begin
			expAdvance = !modelValid[2] || grantReady_i;
			checkValid(modelValid[2]);
			checkReady(expAdvance); // Ready drops only while output held
			if (holdPending)
			begin
				if (!grantValid_o)
					failRun("grantValid_o dropped while the result was being held");
				checkGrant(heldGrant, grant_o); // Must not move during a stall
			end
			holdPending = grantValid_o && !grantReady_i;
			heldGrant = grant_o;
			if (holdPending)
				stallCycles++;
			if (grantValid_o && grantReady_i)
			begin
				if (expQ.size() == 0)
					failRun("a grant came out with no request pending");
				expected = expQ.pop_front();
				latency = cycle - acceptQ.pop_front();
				checkGrant(expected, grant_o);
				if (latencyCheck && latency != 3)
					failRun($sformatf("error test=%s expected latency=3 actual latency=%0d",
						testName, latency));
				grantsSeen++;
			end
			if (reqValid_i && reqReady_o)
			begin
				expQ.push_back(expectedGrant(reqBeat_i));
				acceptQ.push_back(cycle);
			end
			if (expAdvance)
				modelValid = {modelValid[1:0], reqValid_i};
		end
	end

	// Output side drops grantReady_i for random stretches in stall mode
	initial
	begin : readyDriver
		int stallLeft;
		grantReady_i = 1'b1;
		stallLeft = 0;
		forever
		begin
			@(negedge clk);
			if (stallMode && stallLeft == 0 && grantReady_i && ($urandom % 3) == 0)
				stallLeft = 1 + ($urandom % MAX_STALL);
			if (stallMode && stallLeft > 0)
			begin
				grantReady_i = 1'b0;
				stallLeft--;
			end
			else
				grantReady_i = 1'b1;
		end
	end

	task automatic afterResetState();
		testName = "afterResetState";
		if (grantValid_o !== 1'b0)
			failRun("grantValid_o is not low right after reset");
		checkReady(1'b1);
		@(negedge clk);
		if (grantValid_o !== 1'b0)
			failRun("grantValid_o rose with no request sent");
	endtask

	task automatic allPortsRandom();
		testName = "allPortsRandom";
		for (int n = 0; n < RAND_BEATS; n++)
			sendBeat(randomReq(n), 3'b111);
		waitDrain();
	endtask

	task automatic partialEnables();
		testName = "partialEnables";
		for (int en = 0; en < 8; en++)
		begin
			for (int n = 0; n < PATTERN_VECS; n++)
				sendBeat(randomReq(n), en[2:0]); // Covers 101 and 010 too
		end
		waitDrain();
	endtask

	task automatic cornerVectors();
		issueSelPkg::reqVecT corner[CORNER_VECS];
		testName = "cornerVectors";
		corner[0] = 32'h0000_0000; // Empty
		corner[1] = 32'h0000_FF00; // Full second block
		corner[2] = 32'h8040_2010; // One per block
		corner[3] = 32'hFF00_0000; // Last block only
		for (int en = 0; en < 8; en++)
		begin
			for (int n = 0; n < CORNER_VECS; n++)
				sendBeat(corner[n], en[2:0]);
		end
		waitDrain();
	endtask

	task automatic streamBackToBack();
		testName = "streamBackToBack";
		latencyCheck = 1'b1;
		for (int n = 0; n < STREAM_BEATS; n++)
			sendBeat(randomReq(n), 3'b111); // One accept per cycle
		waitDrain();
		latencyCheck = 1'b0;
	endtask

	task automatic backPressureStalls();
		testName = "backPressureStalls";
		stallCycles = 0;
		stallMode = 1'b1;
		for (int n = 0; n < STALL_BEATS; n++)
			sendBeat(randomReq(n), issueSelPkg::portMaskT'($urandom));
		stallMode = 1'b0;
		waitDrain();
		if (stallCycles == 0)
			failRun("back-pressure test never held the output");
	endtask

	initial
	begin
		#(WATCHDOG_NS);
		failRun($sformatf("Watchdog expired after %0d ns, the DUT stopped moving", WATCHDOG_NS));
	end

	initial
	begin
		void'($urandom(32'h7862_8290));
		rstN_i = 1'b0;
		reqValid_i = 1'b0;
		reqBeat_i = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rstN_i = 1'b1;
		afterResetState();
		allPortsRandom();
		partialEnables();
		cornerVectors();
		streamBackToBack();
		backPressureStalls();
		repeat (4) @(negedge clk);
		if (expQ.size() == 0 && grantsSeen == beatCount)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			failRun($sformatf("%0d beats accepted but %0d grants seen", beatCount, grantsSeen));
	end

endmodule

// ==== all.f ====
issueSelPkg.sv
cascadePick.sv
blockSelect.sv
treeSelect.sv
grantEncode.sv
issueSelect.sv
tb_issueSelect.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --timescale 1ns/100ps -Wno-fatal
TOP ?= tb_issueSelect
FILELIST ?= all.f
OBJDIR ?= obj_dir
LOG ?= sim.log

SOURCES := $(shell cat $(FILELIST))
BINARY := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The simulator status is ignored here, the log decides
run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@grep -q "Regression passed" $(LOG) || \
		(echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)
